// ==== ntm_matrix_mod.f ====
hdl/ntm_arith_pkg.sv
hdl/ntm_ctrl_pkg.sv
hdl/ntm_scalar_mod.sv
hdl/ntm_index_counter.sv
hdl/ntm_matrix_mod_fsm.sv
hdl/ntm_matrix_mod.sv
verif/ntm_matrix_mod_tb.sv

// ==== Makefile ====
TB_TOP = ntm_matrix_mod_tb

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f ntm_matrix_mod.f \
		--top-module $(TB_TOP) -o sim

run: build
	./obj_dir/sim | tee sim.log
	grep -q "TESTBENCH PASSED" sim.log

lint:
	verilator --lint-only -Wall -f ntm_matrix_mod.f --top-module ntm_matrix_mod

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean

// ==== verif/ntm_matrix_mod_tb.sv ====
////////////////////////////////////////////////////////////////////////////
// Testbench of the element-wise matrix modulo unit
// Clock, reset, job stimulus, reference queue, checks and watchdog
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module ntm_matrix_mod_tb;

  localparam int lat = ntm_ctrl_pkg::mod_latency;
  // Element count summed over all jobs (12 + 1 + 1 + 6 + 4 + 3)
  localparam int n_elements = 27;
  localparam int watchdog_cycles = n_elements * (lat + 4) + 150;

  logic                  CLK = 1'b0;
  logic                  RST;
  logic                  start;
  logic                  data_in_i_enable;
  logic                  data_in_j_enable;
  ntm_arith_pkg::data_t  modulo_in;
  ntm_arith_pkg::index_t size_i_in;
  ntm_arith_pkg::index_t size_j_in;
  ntm_arith_pkg::data_t  data_in;
  logic                  ready;
  logic                  data_out_i_enable;
  logic                  data_out_j_enable;
  ntm_arith_pkg::data_t  data_out;

  // Reference model queues
  // Strobe kind is 0 for a column step, 1 for a row end and 2 for the matrix end
  ntm_arith_pkg::data_t exp_data_q[$];
  logic [1:0]           exp_kind_q[$];
  ntm_arith_pkg::data_t exp_data;
  logic [1:0]           exp_kind;
  logic                 exp_accept;
  logic [lat+1:0]       accept_pipe;
  logic                 seen_result;
  int                   accepted;
  int                   results;
  logic [31:0]          rng;
  int                   rows;
  int                   cols;
  int                   row;
  int                   col;

  ntm_matrix_mod DUT (
    .CLK              (CLK),
    .RST              (RST),
    .start            (start),
    .data_in_i_enable (data_in_i_enable),
    .data_in_j_enable (data_in_j_enable),
    .modulo_in        (modulo_in),
    .size_i_in        (size_i_in),
    .size_j_in        (size_j_in),
    .data_in          (data_in),
    .ready            (ready),
    .data_out_i_enable(data_out_i_enable),
    .data_out_j_enable(data_out_j_enable),
    .data_out         (data_out)
  );

  always #50 CLK = ~CLK;

  ////////////////////////////////////////////////////////////////////////////
  // Failure reporting and random numbers
  ////////////////////////////////////////////////////////////////////////////

  task automatic stop_with_failure();
    $display("TESTBENCH FAILED");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic report_mismatch(string name, logic [31:0] got, logic [31:0] exp);
    $display("CHECK FAILED at %0t: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
    stop_with_failure();
  endtask

  task automatic abort_run(string why);
    $display("ERROR at %0t: %s", $time, why);
    stop_with_failure();
  endtask

  function automatic logic [31:0] next_random(logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Result tracking and checks
  ////////////////////////////////////////////////////////////////////////////

  // Accepts delayed to the cycle where their result strobe is due
  always @(posedge CLK or posedge RST) begin
    if (RST) begin
      accept_pipe <= '0;
    end else begin
      accept_pipe <= {accept_pipe[lat:0], exp_accept};
    end
  end

  // Head of the model queue for the strobe now on the outputs
  always @(negedge CLK) begin
    if (!RST && data_out_j_enable) begin
      if (exp_data_q.size() == 0) begin
        abort_run("result strobe with no accepted element outstanding");
      end else begin
        exp_data = exp_data_q.pop_front();
        exp_kind = exp_kind_q.pop_front();
        results++;
        seen_result = 1'b1;
      end
    end
  end

  a_strobe_timing: assert property (@(posedge CLK) disable iff (RST)
    data_out_j_enable == accept_pipe[lat+1])
    else report_mismatch("data_out_j_enable", 32'($sampled(data_out_j_enable)),
                         32'($sampled(accept_pipe[lat+1])));

  a_result_value: assert property (@(posedge CLK) disable iff (RST)
    data_out_j_enable |-> (data_out == exp_data))
    else report_mismatch("data_out", 32'($sampled(data_out)), 32'($sampled(exp_data)));

  a_row_strobe: assert property (@(posedge CLK) disable iff (RST)
    data_out_i_enable == (data_out_j_enable && exp_kind == 2'd1))
    else report_mismatch("data_out_i_enable", 32'($sampled(data_out_i_enable)),
                         32'($sampled(data_out_j_enable && exp_kind == 2'd1)));

  a_ready_strobe: assert property (@(posedge CLK) disable iff (RST)
    ready == (data_out_j_enable && exp_kind == 2'd2))
    else report_mismatch("ready", 32'($sampled(ready)),
                         32'($sampled(data_out_j_enable && exp_kind == 2'd2)));

  // Output bus stays cleared from reset up to the first result
  a_quiet_after_reset: assert property (@(posedge CLK) disable iff (RST)
    !seen_result |-> (data_out == '0))
    else report_mismatch("data_out", 32'($sampled(data_out)), 32'd0);

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus driven on the falling edge
  ////////////////////////////////////////////////////////////////////////////

  task automatic start_job(ntm_arith_pkg::index_t si, ntm_arith_pkg::index_t sj);
    size_i_in = si;
    size_j_in = sj;
    start = 1'b1;
    // Zero size runs as one
    rows = (si == '0) ? 1 : int'(si);
    cols = (sj == '0) ? 1 : int'(sj);
    row = 0;
    col = 0;
    @(negedge CLK);
    start = 1'b0;
  endtask

  task automatic send_element(ntm_arith_pkg::data_t value, ntm_arith_pkg::data_t modulus,
                              bit noisy);
    logic       first;
    logic [1:0] kind;
    int         waited;
    first = (col == 0);
    if (noisy) begin
      // Wrong enable kind for this position first
      data_in_i_enable = !first;
      data_in_j_enable = first;
      @(negedge CLK);
    end
    data_in = value;
    modulo_in = modulus;
    data_in_i_enable = first;
    data_in_j_enable = !first;
    exp_accept = 1'b1;
    kind = (col == cols - 1) ? ((row == rows - 1) ? 2'd2 : 2'd1) : 2'd0;
    exp_data_q.push_back((modulus == '0) ? value : value % modulus);
    exp_kind_q.push_back(kind);
    accepted++;
    if (col == cols - 1) begin
      col = 0;
      row++;
    end else begin
      col++;
    end
    @(negedge CLK);
    data_in_i_enable = 1'b0;
    data_in_j_enable = 1'b0;
    exp_accept = 1'b0;
    // Operands must have been captured on the accept edge
    data_in = ~value;
    modulo_in = '0;
    if (noisy) begin
      @(negedge CLK);
      data_in_i_enable = 1'b1;
      data_in_j_enable = 1'b1;
      @(negedge CLK);
      data_in_i_enable = 1'b0;
      data_in_j_enable = 1'b0;
    end
    waited = 0;
    while (!data_out_j_enable && waited <= lat + 4) begin
      @(negedge CLK);
      waited++;
    end
    if (!data_out_j_enable) begin
      abort_run("no result strobe after an accepted element");
    end
  endtask

  task automatic send_random(bit noisy);
    ntm_arith_pkg::data_t value;
    ntm_arith_pkg::data_t modulus;
    rng = next_random(rng);
    value = rng[15:0];
    // Random shift spreads moduli over small and large values
    modulus = ntm_arith_pkg::data_t'(rng[31:16] >> rng[3:0]);
    if (modulus == '0) begin
      modulus = 16'd3;
    end
    send_element(value, modulus, noisy);
  endtask

  initial begin
    repeat (watchdog_cycles) @(posedge CLK);
    abort_run("watchdog expired before the test sequence finished");
  end

  initial begin
    rng = 32'd40856;
    RST = 1'b1;
    start = 1'b0;
    data_in_i_enable = 1'b0;
    data_in_j_enable = 1'b0;
    modulo_in = '0;
    size_i_in = '0;
    size_j_in = '0;
    data_in = '0;
    exp_accept = 1'b0;
    exp_data = '0;
    exp_kind = 2'd0;
    seen_result = 1'b0;
    accepted = 0;
    results = 0;
    repeat (2) @(posedge CLK);
    @(negedge CLK);
    RST = 1'b0;
    repeat (3) @(negedge CLK);

    // 3 by 4 job of random data with stray and wrong-kind enables
    start_job(8'd3, 8'd4);
    repeat (12) send_random(1'b1);
    start_job(8'd1, 8'd1);
    send_random(1'b0);
    start_job(8'd0, 8'd0);
    send_random(1'b0);

    // Edge values
    start_job(8'd2, 8'd3);
    send_element(16'h1234, 16'h0000, 1'b0);
    send_element(16'hbeef, 16'h0001, 1'b0);
    send_element(16'h0005, 16'h0009, 1'b0);
    send_element(16'hffff, 16'hffff, 1'b0);
    send_element(16'h0000, 16'h0003, 1'b0);
    send_element(16'h0041, 16'h0040, 1'b0);

    // Back-to-back jobs started in the ready cycle
    start_job(8'd2, 8'd2);
    repeat (4) send_random(1'b0);
    start_job(8'd3, 8'd1);
    repeat (3) send_random(1'b1);

    // Enables in idle are ignored
    repeat (4) begin
      @(negedge CLK);
      data_in_i_enable = 1'b1;
      data_in_j_enable = 1'b1;
    end
    @(negedge CLK);
    data_in_i_enable = 1'b0;
    data_in_j_enable = 1'b0;
    repeat (lat + 4) @(negedge CLK);

    if (results != accepted) begin
      report_mismatch("result count", 32'(results), 32'(accepted));
    end else begin
      $display("TESTBENCH PASSED");
      $finish;
    end
  end

endmodule

// ==== hdl/ntm_matrix_mod.sv ====
////////////////////////////////////////////////////////////////////////////
// Element-wise matrix modulo unit, top level
// Sequencer, index counter and remainder datapath
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module ntm_matrix_mod (
  input  logic                  CLK,
  input  logic                  RST,
  input  logic                  start,
  input  logic                  data_in_i_enable,
  input  logic                  data_in_j_enable,
  input  ntm_arith_pkg::data_t  modulo_in,
  input  ntm_arith_pkg::index_t size_i_in,
  input  ntm_arith_pkg::index_t size_j_in,
  input  ntm_arith_pkg::data_t  data_in,
  output logic                  ready,
  output logic                  data_out_i_enable,
  output logic                  data_out_j_enable,
  output ntm_arith_pkg::data_t  data_out
);

  // Sequencer to datapath
  logic                 op_start;
  logic                 op_done;
  ntm_arith_pkg::data_t op_result;

  // Sequencer to counter
  logic load;
  logic step_j;
  logic step_row;
  logic last_i;
  logic last_j;

  ntm_matrix_mod_fsm u_fsm (
    .CLK              (CLK),
    .RST              (RST),
    .start            (start),
    .data_in_i_enable (data_in_i_enable),
    .data_in_j_enable (data_in_j_enable),
    .last_i           (last_i),
    .last_j           (last_j),
    .op_done          (op_done),
    .op_result        (op_result),
    .op_start         (op_start),
    .load             (load),
    .step_j           (step_j),
    .step_row         (step_row),
    .ready            (ready),
    .data_out_i_enable(data_out_i_enable),
    .data_out_j_enable(data_out_j_enable),
    .data_out         (data_out)
  );

  ntm_index_counter u_counter (
    .CLK     (CLK),
    .RST     (RST),
    .load    (load),
    .size_i  (size_i_in),
    .size_j  (size_j_in),
    .step_j  (step_j),
    .step_row(step_row),
    .last_i  (last_i),
    .last_j  (last_j)
  );

  // Element and modulus go straight in, captured on the accept edge
  ntm_scalar_mod u_scalar_mod (
    .CLK      (CLK),
    .RST      (RST),
    .op_start (op_start),
    .dividend (data_in),
    .modulus  (modulo_in),
    .op_done  (op_done),
    .op_result(op_result)
  );

endmodule

// ==== hdl/ntm_matrix_mod_fsm.sv ====
////////////////////////////////////////////////////////////////////////////
// Sequencer of the matrix modulo unit
// Element accept, reduction launch, counter steps, output strobes
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module ntm_matrix_mod_fsm (
  input  logic                 CLK,
  input  logic                 RST,
  input  logic                 start,
  input  logic                 data_in_i_enable,
  input  logic                 data_in_j_enable,
  input  logic                 last_i,
  input  logic                 last_j,
  input  logic                 op_done,
  input  ntm_arith_pkg::data_t op_result,
  output logic                 op_start,
  output logic                 load,
  output logic                 step_j,
  output logic                 step_row,
  output logic                 ready,
  output logic                 data_out_i_enable,
  output logic                 data_out_j_enable,
  output ntm_arith_pkg::data_t data_out
);

  ntm_ctrl_pkg::mod_state_e state;

  // Result of the element in flight
  logic result_done;

  ////////////////////////////////////////////////////////////////////////////
  // Handshake decode
  ////////////////////////////////////////////////////////////////////////////

  // Enable only counts in the matching wait state
  assign op_start = ((state == ntm_ctrl_pkg::wait_i) && data_in_i_enable) ||
                    ((state == ntm_ctrl_pkg::wait_j) && data_in_j_enable);

  // Sizes captured only from idle
  assign load = (state == ntm_ctrl_pkg::idle) && start;

  assign result_done = (state == ntm_ctrl_pkg::busy) && op_done;

  // Counter steps with every result but the final one
  assign step_j   = result_done && !last_j;
  assign step_row = result_done && last_j && !last_i;

  ////////////////////////////////////////////////////////////////////////////
  // State and output strobes
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state             <= ntm_ctrl_pkg::idle;
      ready             <= 1'b0;
      data_out_i_enable <= 1'b0;
      data_out_j_enable <= 1'b0;
      data_out          <= '0;
    end else begin
      // Strobes are single-cycle
      ready             <= 1'b0;
      data_out_i_enable <= 1'b0;
      data_out_j_enable <= 1'b0;
      case (state)
        ntm_ctrl_pkg::idle: begin
          if (start) state <= ntm_ctrl_pkg::wait_i;
        end
        ntm_ctrl_pkg::wait_i: begin
          if (data_in_i_enable) state <= ntm_ctrl_pkg::busy;
        end
        ntm_ctrl_pkg::wait_j: begin
          if (data_in_j_enable) state <= ntm_ctrl_pkg::busy;
        end
        ntm_ctrl_pkg::busy: begin
          if (op_done) begin
            data_out          <= op_result;
            data_out_j_enable <= 1'b1;
            if (last_i && last_j) begin
              // End of matrix
              ready <= 1'b1;
              state <= ntm_ctrl_pkg::idle;
            end else if (last_j) begin
              // End of row so the next element opens a row
              data_out_i_enable <= 1'b1;
              state             <= ntm_ctrl_pkg::wait_i;
            end else begin
              state <= ntm_ctrl_pkg::wait_j;
            end
          end
        end
        default: state <= ntm_ctrl_pkg::idle;
      endcase
    end
  end

  // Matrix end is always also a column step
  a_ready_with_j: assert property (@(posedge CLK) disable iff (RST)
    ready |-> data_out_j_enable);

  // Datapath done only while an element is in flight
  a_done_in_busy: assert property (@(posedge CLK) disable iff (RST)
    op_done |-> (state == ntm_ctrl_pkg::busy));

  // Done is raised mod_latency edges after the capture edge
  a_done_latency: assert property (@(posedge CLK) disable iff (RST)
    op_start |-> ##(ntm_ctrl_pkg::mod_latency + 1) op_done);

endmodule

// ==== hdl/ntm_index_counter.sv ====
////////////////////////////////////////////////////////////////////////////
// Row and column index counter
// Size capture with zero clamped to one, last-element flags
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module ntm_index_counter (
  input  logic                  CLK,
  input  logic                  RST,
  input  logic                  load,
  input  ntm_arith_pkg::index_t size_i,
  input  ntm_arith_pkg::index_t size_j,
  input  logic                  step_j,
  input  logic                  step_row,
  output logic                  last_i,
  output logic                  last_j
);

  // Captured sizes
  ntm_arith_pkg::index_t size_i_q;
  ntm_arith_pkg::index_t size_j_q;

  // Current row and column
  ntm_arith_pkg::index_t idx_i_q;
  ntm_arith_pkg::index_t idx_j_q;

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      size_i_q <= ntm_arith_pkg::index_t'(1);
      size_j_q <= ntm_arith_pkg::index_t'(1);
      idx_i_q  <= '0;
      idx_j_q  <= '0;
    end else if (load) begin
      // Zero-sized dimension runs as a single element
      size_i_q <= (size_i == '0) ? ntm_arith_pkg::index_t'(1) : size_i;
      size_j_q <= (size_j == '0) ? ntm_arith_pkg::index_t'(1) : size_j;
      idx_i_q  <= '0;
      idx_j_q  <= '0;
    end else if (step_row) begin
      // Row wrap
      idx_i_q <= idx_i_q + 1'b1;
      idx_j_q <= '0;
    end else if (step_j) begin
      idx_j_q <= idx_j_q + 1'b1;
    end
  end

  // Sizes never below one, so no underflow here
  assign last_i = (idx_i_q == ntm_arith_pkg::index_t'(size_i_q - 1'b1));
  assign last_j = (idx_j_q == ntm_arith_pkg::index_t'(size_j_q - 1'b1));

  // Final element ends the job, nothing may step past it
  a_no_step_past_end: assert property (@(posedge CLK) disable iff (RST)
    (step_j || step_row) |-> !(last_i && last_j));

endmodule

// ==== hdl/ntm_scalar_mod.sv ====
////////////////////////////////////////////////////////////////////////////
// Bit-serial restoring remainder datapath
// One dividend bit per clock, done pulse after data_w steps
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module ntm_scalar_mod (
  input  logic                 CLK,
  input  logic                 RST,
  input  logic                 op_start,
  input  ntm_arith_pkg::data_t dividend,
  input  ntm_arith_pkg::data_t modulus,
  output logic                 op_done,
  output ntm_arith_pkg::data_t op_result
);

  // Control state
  logic running;
  logic [$clog2(ntm_ctrl_pkg::mod_latency)-1:0] count_q;

  // Operands and partial remainder
  ntm_arith_pkg::data_t dvd_q;
  ntm_arith_pkg::data_t mod_q;
  ntm_arith_pkg::data_t rem_q;

  // One restoring step
  logic [ntm_arith_pkg::data_w:0] shifted;
  ntm_arith_pkg::data_t           rem_next;

  ////////////////////////////////////////////////////////////////////////////
  // Restoring step
  ////////////////////////////////////////////////////////////////////////////

  // Bring down the next dividend bit, MSB first
  assign shifted = {rem_q, dvd_q[ntm_arith_pkg::data_w-1]};

  // Subtract when not smaller; a zero modulus always subtracts nothing,
  // so the remainder ends up as the dividend itself
  always_comb begin
    if (shifted >= {1'b0, mod_q}) begin
      rem_next = ntm_arith_pkg::data_t'(shifted - {1'b0, mod_q});
    end else begin
      rem_next = shifted[ntm_arith_pkg::data_w-1:0];
    end
  end

  // Sequencing of the data_w steps
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      running <= 1'b0;
      count_q <= '0;
      op_done <= 1'b0;
    end else begin
      op_done <= 1'b0;
      if (op_start) begin
        running <= 1'b1;
        count_q <= '0;
      end else if (running) begin
        count_q <= count_q + 1'b1;
        // Last step lands together with the done pulse
        if (count_q == $bits(count_q)'(ntm_ctrl_pkg::mod_latency - 1)) begin
          running <= 1'b0;
          op_done <= 1'b1;
        end
      end
    end
  end

  // Operand capture and remainder update
  always_ff @(posedge CLK) begin
    if (op_start) begin
      dvd_q <= dividend;
      mod_q <= modulus;
      rem_q <= '0;
    end else if (running) begin
      dvd_q <= dvd_q << 1;
      rem_q <= rem_next;
    end
  end

  assign op_result = rem_q;

  // No new operand while a reduction is in flight
  a_no_start_busy: assert property (@(posedge CLK) disable iff (RST)
    op_start |-> !running);

  // Done is a single-cycle pulse
  a_done_pulse: assert property (@(posedge CLK) disable iff (RST)
    op_done |=> !op_done);

endmodule

// ==== hdl/ntm_ctrl_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// Control encodings of the matrix modulo unit
// Sequencer states and remainder latency
////////////////////////////////////////////////////////////////////////////

package ntm_ctrl_pkg;

  // Sequencer states
  typedef enum logic [1:0] {
    idle,
    wait_i,
    wait_j,
    busy
  } mod_state_e;

  // Cycles from a remainder start edge to its done pulse, one per bit
  localparam int mod_latency = ntm_arith_pkg::data_w;

endpackage

// ==== hdl/ntm_arith_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// Arithmetic widths of the matrix modulo unit
// Element, modulus and index vector types
////////////////////////////////////////////////////////////////////////////

package ntm_arith_pkg;

  // Element and modulus width in bits
  localparam int data_w = 16;

  // Row and column count width in bits
  localparam int index_w = 8;

  // Elements, moduli and remainders
  typedef logic [data_w-1:0] data_t;

  // Matrix sizes and loop indices
  typedef logic [index_w-1:0] index_t;

endpackage
